/* cu_params.svh */
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// Instruction byte
`define CU_OPCODE_W 8

// Sequencer state register, 25 states
`define CU_STATE_W 5

// ALU operation code
`define CU_ALU_OP_W 6

// Memory address source mux
`define CU_ADDR_SEL_W 4

// ALU operand mux
`define CU_OPERAND_SEL_W 3

// Memory write data mux
`define CU_WRITE_SEL_W 3

`define CU_SP_OP_W 2 // Stack pointer hold, inc, dec
`define CU_DEST_W 3 // Register load target

`endif

/* cu_pkg.sv */
`default_nettype none

`include "cu_params.svh"

package cu_pkg;

	typedef logic [`CU_OPCODE_W-1:0] opcode_t;
	typedef logic [`CU_ALU_OP_W-1:0] alu_op_t;
	typedef logic [`CU_ADDR_SEL_W-1:0] addr_sel_t;
	typedef logic [`CU_OPERAND_SEL_W-1:0] operand_sel_t;
	typedef logic [`CU_WRITE_SEL_W-1:0] write_sel_t;
	typedef logic [`CU_SP_OP_W-1:0] sp_op_t;

	// ALU operation codes, address generation first
	localparam alu_op_t ALU_ADR0 = 6'h00; // Low address byte add
	localparam alu_op_t ALU_ADR1 = 6'h01; // High byte plus carry
	localparam alu_op_t ALU_ADC = 6'h02;
	localparam alu_op_t ALU_AND = 6'h03;
	localparam alu_op_t ALU_ASL = 6'h04;
	localparam alu_op_t ALU_BIT = 6'h05;
	localparam alu_op_t ALU_BCC = 6'h06;
	localparam alu_op_t ALU_BNE = 6'h07;
	localparam alu_op_t ALU_BVC = 6'h0C;
	localparam alu_op_t ALU_BPL = 6'h0D;
	localparam alu_op_t ALU_BCS = 6'h0E;
	localparam alu_op_t ALU_BEQ = 6'h0F;
	localparam alu_op_t ALU_BVS = 6'h14;
	localparam alu_op_t ALU_BMI = 6'h15;
	localparam alu_op_t ALU_BRA = 6'h16;
	localparam alu_op_t ALU_CLC = 6'h17;
	localparam alu_op_t ALU_CLI = 6'h18;
	localparam alu_op_t ALU_CLD = 6'h19;
	localparam alu_op_t ALU_CLV = 6'h1A;
	localparam alu_op_t ALU_CMP = 6'h1B; // Also CPX and CPY
	localparam alu_op_t ALU_DEC = 6'h1C;
	localparam alu_op_t ALU_EOR = 6'h1D;
	localparam alu_op_t ALU_INC = 6'h1E;
	localparam alu_op_t ALU_LOAD = 6'h1F; // Loads and pulls
	localparam alu_op_t ALU_PASS = 6'h20;
	localparam alu_op_t ALU_LSR = 6'h21;
	localparam alu_op_t ALU_ORA = 6'h22;
	localparam alu_op_t ALU_ROL = 6'h2B;
	localparam alu_op_t ALU_ROR = 6'h2C;
	localparam alu_op_t ALU_SBC = 6'h2D;
	localparam alu_op_t ALU_SEC = 6'h2E;
	localparam alu_op_t ALU_SEI = 6'h2F;
	localparam alu_op_t ALU_SED = 6'h30;
	localparam alu_op_t ALU_TRB = 6'h39;
	localparam alu_op_t ALU_TSB = 6'h3A;

	localparam addr_sel_t ADDR_PC = 4'b0000;
	localparam addr_sel_t ADDR_ZERO = 4'b0001;
	localparam addr_sel_t ADDR_ABS = 4'b0010;
	localparam addr_sel_t ADDR_STACK = 4'b0111;
	localparam addr_sel_t ADDR_RVL = 4'b1010; // Reset vector low
	localparam addr_sel_t ADDR_RVH = 4'b1011;

	localparam operand_sel_t OPND_A = 3'b000;
	localparam operand_sel_t OPND_F = 3'b001; // Status flags
	localparam operand_sel_t OPND_M = 3'b010; // Memory data
	localparam operand_sel_t OPND_SP = 3'b011;
	localparam operand_sel_t OPND_X = 3'b100;
	localparam operand_sel_t OPND_Y = 3'b101;
	localparam operand_sel_t OPND_Z = 3'b110; // Constant zero

	localparam write_sel_t WR_ALU = 3'b000;
	localparam write_sel_t WR_RESULT = 3'b001; // RMW result register
	localparam write_sel_t WR_PCL = 3'b010;
	localparam write_sel_t WR_PCH = 3'b011;
	localparam write_sel_t WR_ZERO_BYTE = 3'b101;

	localparam sp_op_t SP_HOLD = 2'b00;
	localparam sp_op_t SP_INC = 2'b01;
	localparam sp_op_t SP_DEC = 2'b10;

	typedef enum logic [`CU_STATE_W-1:0] {
		FETCH, IMP, IMM, ZP0, ZP1, ABS0, ABS1, ABS2,
		ZP_WRITE, ABS_WRITE, ZP_STORE, ABS_STORE,
		BRANCH_CHECK, BRANCH_GO, PUSH, PULL, ABS_JMP,
		JSR0, JSR1, JSR2, RTS0, RTS1, RST0, RST1, RST2
	} cu_state_t;

	typedef enum logic [`CU_DEST_W-1:0] {
		NONE, DEST_A, DEST_X, DEST_Y, DEST_SP
	} reg_dest_t;

	typedef struct packed {
		logic storing; // STA, STX, STY, STZ
		logic writing; // Memory read-modify-write
		logic jump_nosave; // JMP abs
		logic jump_save; // JSR
		reg_dest_t dest;
	} instr_class_t;

	typedef struct packed {
		logic instruction_load;
		logic increment_pc;
		logic dirl_load;
		logic dirh_load;
		logic a_load;
		logic x_load;
		logic y_load;
		logic sp_load;
		logic branch_load;
		logic pcl_load;
		logic pch_load;
		logic jmp_load;
		logic jsr_load;
		logic rst_load;
	} cu_strobes_t;

	typedef struct packed {
		logic read_write; // 0 is read
		write_sel_t write_select;
		addr_sel_t address_select;
		sp_op_t sp_op;
	} bus_ctrl_t;

	typedef struct packed {
		operand_sel_t alu_select;
		alu_op_t alu_opcode;
	} alu_ctrl_t;

endpackage

`default_nettype wire

/* opcode_classifier.sv */
`timescale 1ns/100ps
`default_nettype none

module opcode_classifier (
	input wire cu_pkg::opcode_t opcode_reg,
	output cu_pkg::instr_class_t cls
);

	always_comb begin
		cls = '0;

		casez (opcode_reg)
			8'b100?_?10?,
			8'b100?_?110,
			8'h99,
			8'b011?_0100: cls.storing = 1'b1; // STA, STX, STY, STZ
			default: cls.storing = 1'b0;
		endcase

		casez (opcode_reg)
			8'b000?_?1?0, // TSB, TRB, ASL
			8'b0???_?110, // ASL, ROL, LSR, ROR
			8'b11??_?110: cls.writing = 1'b1; // DEC, INC
			default: cls.writing = 1'b0;
		endcase

		cls.jump_nosave = (opcode_reg == 8'h4C); // Indirect forms dropped
		cls.jump_save = (opcode_reg == 8'h20);

		// Register written in the final load cycle
		casez (opcode_reg)
			8'b0???_??01, // ORA, AND, EOR, ADC
			8'b101?_??01, // LDA
			8'b111?_??01, // SBC
			8'b0??0_1010, // Accumulator shifts
			8'b00?1_1010, // INC A, DEC A
			8'h68,
			8'h8A,
			8'h98: cls.dest = cu_pkg::DEST_A;
			8'b101?_?110,
			8'hA2,
			8'b101?_1010, // TAX, TSX
			8'hE8,
			8'hCA,
			8'hFA: cls.dest = cu_pkg::DEST_X;
			8'b101?_?100,
			8'hA0,
			8'hA8,
			8'hC8,
			8'h88,
			8'h7A: cls.dest = cu_pkg::DEST_Y;
			8'h9A: cls.dest = cu_pkg::DEST_SP; // TXS
			default: cls.dest = cu_pkg::NONE;
		endcase
	end

endmodule

`default_nettype wire

/* cycle_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module cycle_sequencer (
	input wire clk,
	input wire rst,
	input wire cu_pkg::opcode_t opcode,
	input wire cu_pkg::instr_class_t cls,
	input wire branch_valid,
	output cu_pkg::cu_state_t state
);

	cu_pkg::cu_state_t state_next;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= cu_pkg::RST0;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = cu_pkg::FETCH;
		case (state)
			cu_pkg::FETCH: begin
				// Dispatch on the byte arriving from memory
				casez (opcode)
					8'h20,
					8'h4C: state_next = cu_pkg::ABS0; // JSR, JMP abs
					8'h60: state_next = cu_pkg::RTS0;
					8'b011?_1100: state_next = cu_pkg::FETCH; // Indirect JMP unsupported
					8'b0?00_1000,
					8'b?101_1010: state_next = cu_pkg::PUSH;
					8'b0?10_1000,
					8'b?111_1010: state_next = cu_pkg::PULL;
					8'b???1_0000,
					8'h80: state_next = cu_pkg::BRANCH_CHECK;
					8'b????_1000,
					8'b????_1010: state_next = cu_pkg::IMP;
					8'b1010_00?0,
					8'b11?0_0000,
					8'b???0_1001: state_next = cu_pkg::IMM;
					8'b????_010?,
					8'b????_0110: state_next = cu_pkg::ZP0;
					8'b????_110?,
					8'b????_1110,
					8'b???1_1001: state_next = cu_pkg::ABS0;
					default: state_next = cu_pkg::FETCH; // Unknown, refetch
				endcase
			end
			cu_pkg::ZP0: begin
				state_next = cls.storing ? cu_pkg::ZP_STORE : cu_pkg::ZP1;
			end
			cu_pkg::ZP1: begin
				state_next = cls.writing ? cu_pkg::ZP_WRITE : cu_pkg::FETCH;
			end
			cu_pkg::ABS0: begin
				state_next = cls.jump_nosave ? cu_pkg::ABS_JMP : cu_pkg::ABS1;
			end
			cu_pkg::ABS1: begin
				if (cls.storing) begin
					state_next = cu_pkg::ABS_STORE;
				end else if (cls.jump_save) begin
					state_next = cu_pkg::JSR0;
				end else begin
					state_next = cu_pkg::ABS2;
				end
			end
			cu_pkg::ABS2: begin
				state_next = cls.writing ? cu_pkg::ABS_WRITE : cu_pkg::FETCH;
			end
			cu_pkg::BRANCH_CHECK: begin
				state_next = branch_valid ? cu_pkg::BRANCH_GO : cu_pkg::FETCH;
			end
			cu_pkg::JSR0: state_next = cu_pkg::JSR1;
			cu_pkg::JSR1: state_next = cu_pkg::JSR2;
			cu_pkg::RTS0: state_next = cu_pkg::RTS1;
			cu_pkg::RST0: state_next = cu_pkg::RST1;
			cu_pkg::RST1: state_next = cu_pkg::RST2;
			default: state_next = cu_pkg::FETCH; // Single-cycle execute states
		endcase
	end

endmodule

`default_nettype wire

/* bus_control_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_control_decoder (
	input wire cu_pkg::cu_state_t state,
	input wire cu_pkg::reg_dest_t dest,
	output cu_pkg::cu_strobes_t strobes,
	output cu_pkg::bus_ctrl_t bus
);

	logic load; // Last cycle of a register-writing instruction

	always_comb begin
		strobes = '0;
		bus.read_write = 1'b0;
		bus.write_select = cu_pkg::WR_ZERO_BYTE;
		bus.address_select = cu_pkg::ADDR_PC;
		bus.sp_op = cu_pkg::SP_HOLD;
		load = 1'b0;

		case (state)
			cu_pkg::FETCH: begin
				strobes.instruction_load = 1'b1;
				strobes.increment_pc = 1'b1;
			end
			cu_pkg::IMP: load = 1'b1;
			cu_pkg::IMM: begin
				strobes.increment_pc = 1'b1;
				load = 1'b1;
			end
			cu_pkg::ZP0,
			cu_pkg::ABS0: begin
				strobes.increment_pc = 1'b1;
				strobes.dirl_load = 1'b1; // Operand low byte
			end
			cu_pkg::ABS1: begin
				strobes.increment_pc = 1'b1;
				strobes.dirh_load = 1'b1;
			end
			cu_pkg::ZP1: begin
				bus.address_select = cu_pkg::ADDR_ZERO;
				load = 1'b1;
			end
			cu_pkg::ABS2: begin
				bus.address_select = cu_pkg::ADDR_ABS;
				load = 1'b1;
			end
			cu_pkg::ZP_STORE,
			cu_pkg::ABS_STORE: begin
				bus.read_write = 1'b1;
				bus.write_select = cu_pkg::WR_ALU;
				bus.address_select = (state == cu_pkg::ZP_STORE) ?
					cu_pkg::ADDR_ZERO : cu_pkg::ADDR_ABS;
			end
			cu_pkg::ZP_WRITE,
			cu_pkg::ABS_WRITE: begin
				bus.read_write = 1'b1;
				bus.write_select = cu_pkg::WR_RESULT;
				bus.address_select = (state == cu_pkg::ZP_WRITE) ?
					cu_pkg::ADDR_ZERO : cu_pkg::ADDR_ABS;
			end
			cu_pkg::BRANCH_CHECK: strobes.increment_pc = 1'b1;
			cu_pkg::BRANCH_GO: strobes.branch_load = 1'b1;
			cu_pkg::PUSH: begin
				bus.read_write = 1'b1;
				bus.write_select = cu_pkg::WR_ALU;
				bus.address_select = cu_pkg::ADDR_STACK;
				bus.sp_op = cu_pkg::SP_DEC;
			end
			cu_pkg::PULL: begin
				bus.address_select = cu_pkg::ADDR_STACK;
				bus.sp_op = cu_pkg::SP_INC;
				load = 1'b1;
			end
			cu_pkg::ABS_JMP: strobes.jmp_load = 1'b1;
			cu_pkg::JSR0,
			cu_pkg::JSR1: begin
				// Return address goes out high byte first
				bus.read_write = 1'b1;
				bus.write_select = (state == cu_pkg::JSR0) ? cu_pkg::WR_PCH : cu_pkg::WR_PCL;
				bus.address_select = cu_pkg::ADDR_STACK;
				bus.sp_op = cu_pkg::SP_DEC;
			end
			cu_pkg::JSR2: strobes.jsr_load = 1'b1;
			cu_pkg::RTS0,
			cu_pkg::RTS1: begin
				bus.address_select = cu_pkg::ADDR_STACK;
				bus.sp_op = cu_pkg::SP_INC;
				strobes.pcl_load = (state == cu_pkg::RTS0);
				strobes.pch_load = (state == cu_pkg::RTS1);
			end
			cu_pkg::RST0: strobes.rst_load = 1'b1;
			cu_pkg::RST1: begin
				bus.address_select = cu_pkg::ADDR_RVL;
				strobes.pcl_load = 1'b1;
			end
			cu_pkg::RST2: begin
				bus.address_select = cu_pkg::ADDR_RVH;
				strobes.pch_load = 1'b1;
			end
			default: load = 1'b0;
		endcase

		strobes.a_load = load && (dest == cu_pkg::DEST_A);
		strobes.x_load = load && (dest == cu_pkg::DEST_X);
		strobes.y_load = load && (dest == cu_pkg::DEST_Y);
		strobes.sp_load = load && (dest == cu_pkg::DEST_SP);
	end

endmodule

`default_nettype wire

/* alu_control_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_control_decoder (
	input wire cu_pkg::cu_state_t state,
	input wire cu_pkg::opcode_t opcode_reg,
	output cu_pkg::alu_ctrl_t alu
);

	cu_pkg::operand_sel_t sel_ad; // Index register for address add
	cu_pkg::operand_sel_t sel_ex;
	cu_pkg::alu_op_t op_ex;

	always_comb begin
		casez (opcode_reg)
			8'h14, 8'h1C, 8'h9C: sel_ad = cu_pkg::OPND_Z; // TRB, STZ abs, unindexed
			8'h96, 8'hB6, 8'hBE: sel_ad = cu_pkg::OPND_Y; // zp,Y and LDX abs,Y
			8'b???1_1001: sel_ad = cu_pkg::OPND_Y;
			8'b???1_01??,
			8'b???1_11??: sel_ad = cu_pkg::OPND_X;
			default: sel_ad = cu_pkg::OPND_Z;
		endcase
	end

	always_comb begin
		casez (opcode_reg)
			8'hBA: sel_ex = cu_pkg::OPND_SP; // TSX
			8'h64, 8'h74, 8'h9C, 8'h9E: sel_ex = cu_pkg::OPND_Z; // STZ
			8'b1110_??00, 8'hCA, 8'hDA,
			8'b100?_?110, 8'b100?_1010: sel_ex = cu_pkg::OPND_X;
			8'b1100_??00, 8'h5A,
			8'b100?_?100, 8'b100?_1000: sel_ex = cu_pkg::OPND_Y;
			8'b???1_0000, 8'h80,
			8'b???1_1000, 8'h08: sel_ex = cu_pkg::OPND_F; // Branches, flag ops, PHP
			8'b0???_??01, 8'b11??_??01, 8'b100?_??01,
			8'b0??0_1010, 8'b00?1_1010, 8'h48, 8'hAA, 8'hA8,
			8'b000?_?100, 8'b001?_?100: sel_ex = cu_pkg::OPND_A;
			default: sel_ex = cu_pkg::OPND_M; // Loads, pulls, memory RMW
		endcase
	end

	always_comb begin
		casez (opcode_reg)
			8'b011?_??01: op_ex = cu_pkg::ALU_ADC;
			8'b001?_??01: op_ex = cu_pkg::ALU_AND;
			8'h0A, 8'b000?_?110: op_ex = cu_pkg::ALU_ASL;
			8'h89, 8'b001?_?100: op_ex = cu_pkg::ALU_BIT;
			8'h90: op_ex = cu_pkg::ALU_BCC;
			8'hD0: op_ex = cu_pkg::ALU_BNE;
			8'h50: op_ex = cu_pkg::ALU_BVC;
			8'h10: op_ex = cu_pkg::ALU_BPL;
			8'hB0: op_ex = cu_pkg::ALU_BCS;
			8'hF0: op_ex = cu_pkg::ALU_BEQ;
			8'h70: op_ex = cu_pkg::ALU_BVS;
			8'h30: op_ex = cu_pkg::ALU_BMI;
			8'h80: op_ex = cu_pkg::ALU_BRA;
			8'h18: op_ex = cu_pkg::ALU_CLC;
			8'h58: op_ex = cu_pkg::ALU_CLI;
			8'hD8: op_ex = cu_pkg::ALU_CLD;
			8'hB8: op_ex = cu_pkg::ALU_CLV;
			8'b110?_??01, 8'b11?0_?100, 8'b11?0_0000: op_ex = cu_pkg::ALU_CMP;
			8'h3A, 8'h88, 8'hCA, 8'b110?_?110: op_ex = cu_pkg::ALU_DEC;
			8'b010?_??01: op_ex = cu_pkg::ALU_EOR;
			8'h1A, 8'hC8, 8'hE8, 8'b111?_?110: op_ex = cu_pkg::ALU_INC;
			8'b101?_??01, 8'b101?_?110, 8'b101?_?100, 8'hA0, 8'hA2,
			8'h28, 8'h68, 8'h7A, 8'hFA: op_ex = cu_pkg::ALU_LOAD;
			8'h4A, 8'b010?_?110: op_ex = cu_pkg::ALU_LSR;
			8'b000?_??01: op_ex = cu_pkg::ALU_ORA;
			8'h2A, 8'b001?_?110: op_ex = cu_pkg::ALU_ROL;
			8'h6A, 8'b011?_?110: op_ex = cu_pkg::ALU_ROR;
			8'b111?_??01: op_ex = cu_pkg::ALU_SBC;
			8'h38: op_ex = cu_pkg::ALU_SEC;
			8'h78: op_ex = cu_pkg::ALU_SEI;
			8'hF8: op_ex = cu_pkg::ALU_SED;
			8'b0001_?100: op_ex = cu_pkg::ALU_TRB;
			8'b0000_?100: op_ex = cu_pkg::ALU_TSB;
			default: op_ex = cu_pkg::ALU_PASS; // Stores, pushes, transfers
		endcase
	end

	always_comb begin
		case (state)
			cu_pkg::ZP0,
			cu_pkg::ABS0: begin
				alu.alu_select = sel_ad;
				alu.alu_opcode = cu_pkg::ALU_ADR0;
			end
			cu_pkg::ABS1: begin
				alu.alu_select = cu_pkg::OPND_Z; // Carry into high byte
				alu.alu_opcode = cu_pkg::ALU_ADR1;
			end
			cu_pkg::IMP,
			cu_pkg::IMM,
			cu_pkg::ZP1,
			cu_pkg::ABS2,
			cu_pkg::BRANCH_CHECK: begin
				alu.alu_select = sel_ex;
				alu.alu_opcode = op_ex;
			end
			default: begin
				alu.alu_select = sel_ex; // Store and push data source
				alu.alu_opcode = cu_pkg::ALU_PASS;
			end
		endcase
	end

endmodule

`default_nettype wire

/* control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit (
	input wire clk,
	input wire rst,
	input wire cu_pkg::opcode_t opcode, // Byte on the data bus at fetch
	input wire cu_pkg::opcode_t opcode_reg, // Datapath instruction register
	input wire branch_valid,
	output cu_pkg::cu_strobes_t strobes,
	output cu_pkg::bus_ctrl_t bus,
	output cu_pkg::alu_ctrl_t alu
);

	cu_pkg::instr_class_t cls;
	cu_pkg::cu_state_t state;

	opcode_classifier u_classifier (
		.opcode_reg(opcode_reg),
		.cls(cls)
	);

	cycle_sequencer u_sequencer (
		.clk(clk),
		.rst(rst),
		.opcode(opcode),
		.cls(cls),
		.branch_valid(branch_valid),
		.state(state)
	);

	bus_control_decoder u_bus_decoder (
		.state(state),
		.dest(cls.dest), // Only the load target is needed here
		.strobes(strobes),
		.bus(bus)
	);

	alu_control_decoder u_alu_decoder (
		.state(state),
		.opcode_reg(opcode_reg),
		.alu(alu)
	);

endmodule

`default_nettype wire

/* control_unit_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit_assertions (
	input wire clk,
	input wire rst,
	input wire cu_pkg::cu_strobes_t strobes,
	input wire cu_pkg::bus_ctrl_t bus
);

	int failures = 0;

	// RST0, RST1 and RST2 run before the first fetch
	a_first_fetch: assert property (@(posedge clk)
		$rose(rst) |-> !strobes.instruction_load [*3] ##1 strobes.instruction_load)
	else begin
		failures++;
		$error("first instruction_load not three cycles after reset release");
	end

	// RST0 only follows an edge with rst low
	a_rst_load: assert property (@(posedge clk)
		strobes.rst_load |-> !$past(rst))
	else begin
		failures++;
		$error("rst_load outside the first reset state");
	end

	a_write_source: assert property (@(posedge clk)
		bus.read_write |-> bus.write_select != cu_pkg::WR_ZERO_BYTE)
	else begin
		failures++;
		$error("bus write with the idle write source");
	end

endmodule

bind control_unit control_unit_assertions u_assert (
	.clk(clk),
	.rst(rst),
	.strobes(strobes),
	.bus(bus)
);

`default_nettype wire

/* tb_control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_control_unit;

	typedef struct packed {
		cu_pkg::opcode_t op;
		logic bv; // branch_valid during the instruction
		int cycles; // FETCH to next FETCH
		cu_pkg::reg_dest_t dest;
		int writes; // Write cycles on the bus
		cu_pkg::bus_ctrl_t wbus; // Bus in the first write cycle
		logic branch;
		cu_pkg::alu_ctrl_t alu0; // First cycle after fetch, zero skips the check
	} row_t;

	logic clk;
	logic rst;
	cu_pkg::opcode_t opcode;
	cu_pkg::opcode_t opcode_reg;
	logic branch_valid;
	cu_pkg::cu_strobes_t strobes;
	cu_pkg::bus_ctrl_t bus;
	cu_pkg::alu_ctrl_t alu;

	row_t rows[$];
	cu_pkg::cu_strobes_t cs[$]; // Per-cycle captures of one instruction
	cu_pkg::bus_ctrl_t cb[$];
	cu_pkg::alu_ctrl_t ca[$];
	int errors = 0;
	longint watch_ns = 0;

	control_unit uut (
		.clk(clk),
		.rst(rst),
		.opcode(opcode),
		.opcode_reg(opcode_reg),
		.branch_valid(branch_valid),
		.strobes(strobes),
		.bus(bus),
		.alu(alu)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		if (strobes.instruction_load) opcode_reg <= opcode; // Datapath instruction register
	end

	initial begin
		wait (watch_ns != 0);
		#(watch_ns);
		$display("Timeout: the DUT did not finish the instruction table in time");
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic cu_pkg::bus_ctrl_t make_bus(input logic rw, input cu_pkg::write_sel_t w,
			input cu_pkg::addr_sel_t a, input cu_pkg::sp_op_t s);
		cu_pkg::bus_ctrl_t b;
		b.read_write = rw;
		b.write_select = w;
		b.address_select = a;
		b.sp_op = s;
		return b;
	endfunction

	function automatic cu_pkg::alu_ctrl_t addr_alu(input cu_pkg::operand_sel_t sel);
		cu_pkg::alu_ctrl_t c;
		c.alu_select = sel;
		c.alu_opcode = cu_pkg::ALU_ADR0;
		return c;
	endfunction

	task automatic add_row(input cu_pkg::opcode_t op, input logic bv, input int cycles,
			input cu_pkg::reg_dest_t dest, input int writes, input cu_pkg::bus_ctrl_t wbus,
			input logic branch, input cu_pkg::alu_ctrl_t alu0);
		rows.push_back({op, bv, cycles, dest, writes, wbus, branch, alu0});
	endtask

	task automatic check_strobes(input cu_pkg::cu_strobes_t got, input cu_pkg::cu_strobes_t exp,
			input string msg);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s, strobes %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_bus(input cu_pkg::bus_ctrl_t got, input cu_pkg::bus_ctrl_t exp,
			input string msg);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s, bus %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_alu(input cu_pkg::alu_ctrl_t got, input cu_pkg::alu_ctrl_t exp,
			input string msg);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s, alu %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string msg);
		if (got != exp) begin
			errors++;
			$display("MISMATCH at %0t: %s, count %0d expected %0d", $time, msg, got, exp);
		end
	endtask

	task automatic check_instr(input row_t r, input int cycles);
		int writes;
		int branches;
		int loads;
		int w1;
		cu_pkg::cu_strobes_t got_l;
		cu_pkg::cu_strobes_t exp_l;
		cu_pkg::cu_strobes_t exp_s;
		writes = 0;
		branches = 0;
		loads = 0;
		w1 = -1;
		check_count(cycles, r.cycles, $sformatf("cycles of opcode %h", r.op));
		foreach (cs[k]) begin
			if (cb[k].read_write) begin
				if (w1 < 0) w1 = k;
				writes++;
			end
			branches += cs[k].branch_load;
			if (cs[k].a_load || cs[k].x_load || cs[k].y_load || cs[k].sp_load) loads++;
		end
		check_count(writes, r.writes, $sformatf("write cycles of %h", r.op));
		check_count(branches, r.branch && r.bv, $sformatf("branch loads of %h", r.op));
		if (w1 >= 0) check_bus(cb[w1], r.wbus, $sformatf("first write of %h", r.op));
		exp_l = '0;
		case (r.dest)
			cu_pkg::DEST_A: exp_l.a_load = 1'b1;
			cu_pkg::DEST_X: exp_l.x_load = 1'b1;
			cu_pkg::DEST_Y: exp_l.y_load = 1'b1;
			cu_pkg::DEST_SP: exp_l.sp_load = 1'b1;
			default: exp_l = '0;
		endcase
		check_count(loads, (r.dest == cu_pkg::NONE) ? 0 : 1, $sformatf("loads of %h", r.op));
		if (cs.size() > 0) begin
			got_l = '0;
			got_l.a_load = cs[$].a_load;
			got_l.x_load = cs[$].x_load;
			got_l.y_load = cs[$].y_load;
			got_l.sp_load = cs[$].sp_load;
			check_strobes(got_l, exp_l, $sformatf("load target of %h", r.op));
		end
		if (r.alu0 != '0 && ca.size() > 0) check_alu(ca[0], r.alu0, "address ALU control");
		if (r.op == 8'h20 && cs.size() == 5) begin
			check_bus(cb[3], make_bus(1'b1, cu_pkg::WR_PCL, cu_pkg::ADDR_STACK, cu_pkg::SP_DEC),
				"JSR low byte push");
			exp_s = '0;
			exp_s.jsr_load = 1'b1;
			check_strobes(cs[4], exp_s, "JSR final cycle");
		end
		if (r.op == 8'h60 && cs.size() == 2) begin
			exp_s = '0;
			exp_s.pcl_load = 1'b1;
			check_strobes(cs[0], exp_s, "RTS low byte pull");
			exp_s = '0;
			exp_s.pch_load = 1'b1;
			check_strobes(cs[1], exp_s, "RTS high byte pull");
			foreach (cb[k]) check_bus(cb[k], make_bus(1'b0, cu_pkg::WR_ZERO_BYTE,
				cu_pkg::ADDR_STACK, cu_pkg::SP_INC), "RTS stack read");
		end
		if (r.op == 8'h4C && cs.size() == 2) begin
			exp_s = '0;
			exp_s.jmp_load = 1'b1;
			check_strobes(cs[1], exp_s, "JMP final cycle");
		end
	endtask

	initial begin
		row_t r;
		cu_pkg::cu_strobes_t exp_s;
		int cycles;
		int bv;
		int sum;
		rst = 1'b0;
		opcode = '0;
		opcode_reg = '0;
		branch_valid = 1'b0;
		void'($urandom(66483));

		add_row(8'hEA, 0, 2, cu_pkg::NONE, 0, '0, 0, '0); // NOP
		add_row(8'hE8, 0, 2, cu_pkg::DEST_X, 0, '0, 0, '0);
		add_row(8'hAA, 0, 2, cu_pkg::DEST_X, 0, '0, 0, '0);
		add_row(8'h9A, 0, 2, cu_pkg::DEST_SP, 0, '0, 0, '0);
		add_row(8'hA9, 0, 2, cu_pkg::DEST_A, 0, '0, 0, '0);
		add_row(8'hA2, 0, 2, cu_pkg::DEST_X, 0, '0, 0, '0);
		add_row(8'hA0, 0, 2, cu_pkg::DEST_Y, 0, '0, 0, '0);
		add_row(8'hA5, 0, 3, cu_pkg::DEST_A, 0, '0, 0, addr_alu(cu_pkg::OPND_Z));
		add_row(8'hA6, 0, 3, cu_pkg::DEST_X, 0, '0, 0, '0);
		add_row(8'hA4, 0, 3, cu_pkg::DEST_Y, 0, '0, 0, '0);
		add_row(8'hB5, 0, 3, cu_pkg::DEST_A, 0, '0, 0, addr_alu(cu_pkg::OPND_X));
		add_row(8'hAD, 0, 4, cu_pkg::DEST_A, 0, '0, 0, addr_alu(cu_pkg::OPND_Z));
		add_row(8'hB9, 0, 4, cu_pkg::DEST_A, 0, '0, 0, addr_alu(cu_pkg::OPND_Y));
		add_row(8'h85, 0, 3, cu_pkg::NONE, 1,
			make_bus(1, cu_pkg::WR_ALU, cu_pkg::ADDR_ZERO, cu_pkg::SP_HOLD), 0, '0);
		add_row(8'h8D, 0, 4, cu_pkg::NONE, 1,
			make_bus(1, cu_pkg::WR_ALU, cu_pkg::ADDR_ABS, cu_pkg::SP_HOLD), 0, '0);
		add_row(8'hE6, 0, 4, cu_pkg::NONE, 1,
			make_bus(1, cu_pkg::WR_RESULT, cu_pkg::ADDR_ZERO, cu_pkg::SP_HOLD), 0, '0);
		add_row(8'hEE, 0, 5, cu_pkg::NONE, 1,
			make_bus(1, cu_pkg::WR_RESULT, cu_pkg::ADDR_ABS, cu_pkg::SP_HOLD), 0, '0);
		add_row(8'hF0, 1, 3, cu_pkg::NONE, 0, '0, 1, '0);
		add_row(8'hF0, 0, 2, cu_pkg::NONE, 0, '0, 1, '0);
		add_row(8'h48, 0, 2, cu_pkg::NONE, 1,
			make_bus(1, cu_pkg::WR_ALU, cu_pkg::ADDR_STACK, cu_pkg::SP_DEC), 0, '0);
		add_row(8'h68, 0, 2, cu_pkg::DEST_A, 0, '0, 0, '0);
		add_row(8'h4C, 0, 3, cu_pkg::NONE, 0, '0, 0, '0);
		add_row(8'h20, 0, 6, cu_pkg::NONE, 2,
			make_bus(1, cu_pkg::WR_PCH, cu_pkg::ADDR_STACK, cu_pkg::SP_DEC), 0, '0);
		add_row(8'h60, 0, 3, cu_pkg::NONE, 0, '0, 0, '0);
		add_row(8'h02, 0, 1, cu_pkg::NONE, 0, '0, 0, '0); // Unknown
		add_row(8'h6C, 0, 1, cu_pkg::NONE, 0, '0, 0, '0); // Indirect JMP, dropped
		repeat (4) begin
			bv = $urandom % 2;
			add_row(8'hD0, bv, 2 + bv, cu_pkg::NONE, 0, '0, 1, '0);
		end

		sum = 0;
		foreach (rows[i]) sum += rows[i].cycles;
		watch_ns = (sum + 15) * 2 * 100;
		opcode = rows[0].op;

		repeat (10) @(posedge clk);
		@(negedge clk);
		exp_s = '0;
		exp_s.rst_load = 1'b1;
		check_strobes(strobes, exp_s, "held reset");
		check_bus(bus, make_bus(0, cu_pkg::WR_ZERO_BYTE, cu_pkg::ADDR_PC, cu_pkg::SP_HOLD),
			"held reset");
		@(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check_strobes(strobes, exp_s, "first reset state");
		@(negedge clk);
		exp_s = '0;
		exp_s.pcl_load = 1'b1;
		check_strobes(strobes, exp_s, "reset vector low");
		check_bus(bus, make_bus(0, cu_pkg::WR_ZERO_BYTE, cu_pkg::ADDR_RVL, cu_pkg::SP_HOLD),
			"reset vector low");
		@(negedge clk);
		exp_s = '0;
		exp_s.pch_load = 1'b1;
		check_strobes(strobes, exp_s, "reset vector high");
		check_bus(bus, make_bus(0, cu_pkg::WR_ZERO_BYTE, cu_pkg::ADDR_RVH, cu_pkg::SP_HOLD),
			"reset vector high");
		@(negedge clk);
		exp_s = '0;
		exp_s.instruction_load = 1'b1;
		exp_s.increment_pc = 1'b1;
		check_strobes(strobes, exp_s, "first fetch");

		foreach (rows[i]) begin
			r = rows[i];
			@(posedge clk); // End of FETCH
			opcode <= (i + 1 < rows.size()) ? rows[i + 1].op : 8'hEA;
			branch_valid <= r.bv;
			cs.delete();
			cb.delete();
			ca.delete();
			cycles = 1;
			forever begin
				@(negedge clk);
				if (strobes.instruction_load) break;
				cs.push_back(strobes);
				cb.push_back(bus);
				ca.push_back(alu);
				@(posedge clk);
				cycles++;
			end
			check_instr(r, cycles);
		end

		errors += uut.u_assert.failures;
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
cu_pkg.sv
opcode_classifier.sv
cycle_sequencer.sv
bus_control_decoder.sv
alu_control_decoder.sv
control_unit.sv
control_unit_assertions.sv
tb_control_unit.sv

/* Bender.yml */
package:
  name: control_unit

sources:
  - include_dirs:
      - .
    files:
      - cu_pkg.sv
      - opcode_classifier.sv
      - cycle_sequencer.sv
      - bus_control_decoder.sv
      - alu_control_decoder.sv
      - control_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - control_unit_assertions.sv
      - tb_control_unit.sv
